// ==== fight_chk.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "fight_config.svh"

module fight_chk #(
	parameter int MAX_HEALTH = `DEF_HEALTH
) (
	input wire                    clk,
	input wire                    reset_n,
	input wire fight_pkg::state_t state,
	input wire [`X_W-1:0]         x,
	input wire [`Y_W-1:0]         y,
	input wire [`COLOR_W-1:0]     color,
	input wire                    plot,
	input wire [`X_W-1:0]         pos_a,
	input wire [`X_W-1:0]         pos_b,
	input wire [6:0]              health_a,
	input wire [6:0]              health_b,
	input wire                    win
);

	localparam logic [`X_W-1:0] SCR_W   = `X_W'(`SCREEN_W);
	localparam logic [`Y_W-1:0] SCR_H   = `Y_W'(`SCREEN_H);
	localparam logic [`X_W-1:0] BAR_A   = `X_W'(`BAR_A_X);
	localparam logic [`X_W-1:0] BAR_B   = `X_W'(`BAR_B_X);
	localparam logic [`Y_W-1:0] BAR_Y0  = `Y_W'(`BAR_Y);
	localparam logic [`Y_W-1:0] BAR_HT  = `Y_W'(`BAR_H);
	localparam logic [`X_W-1:0] HP_COLS = `X_W'(MAX_HEALTH);
	localparam logic [6:0]      HP_FULL = 7'(MAX_HEALTH);
	localparam logic [`X_W-1:0] BOX_WD  = `X_W'(`BOX_W);
	localparam logic [`Y_W-1:0] BOX_HT  = `Y_W'(`BOX_H);
	localparam logic [`Y_W-1:0] BOX_Y0  = `Y_W'(`FIGHTER_Y);

	int fail_cnt = 0;

	logic            bar_state;
	logic [`X_W-1:0] bar_col;   // column inside the bar
	logic [`X_W-1:0] bar_hp;

	assign bar_state = (state == fight_pkg::bar_a_st) || (state == fight_pkg::bar_b_st);
	assign bar_col   = (state == fight_pkg::bar_a_st) ? x - BAR_A : x - BAR_B;
	assign bar_hp    = (state == fight_pkg::bar_a_st) ? {1'b0, health_a} : {1'b0, health_b};

	a_reset: assert property (@(posedge clk) !reset_n |=>
		!plot && !win && health_a == HP_FULL && health_b == HP_FULL)
		else begin fail_cnt++; $error("outputs not at reset values"); end

	// nothing drawn before start or after the game ends
	a_quiet: assert property (@(posedge clk) disable iff (!reset_n)
		(state == fight_pkg::reset_st || state == fight_pkg::hold_st ||
		state == fight_pkg::wait_st || state == fight_pkg::win_st) |-> !plot)
		else begin fail_cnt++; $error("pixel plotted outside a frame"); end

	a_fill: assert property (@(posedge clk) disable iff (!reset_n)
		state == fight_pkg::fill_st |->
		plot && color == `COLOR_BLACK && x < SCR_W && y < SCR_H)
		else begin fail_cnt++; $error("fill pixel not black or off screen"); end

	a_bar: assert property (@(posedge clk) disable iff (!reset_n)
		bar_state |-> plot && bar_col < HP_COLS && y - BAR_Y0 < BAR_HT &&
		color == ((bar_col <= bar_hp) ? `COLOR_GREEN : `COLOR_RED))
		else begin fail_cnt++; $error("health bar pixel wrong"); end

	a_box_a: assert property (@(posedge clk) disable iff (!reset_n)
		state == fight_pkg::box_a_st |-> plot && color == `COLOR_A &&
		x - pos_a < BOX_WD && y - BOX_Y0 < BOX_HT)
		else begin fail_cnt++; $error("fighter A pixel outside its box"); end

	a_box_b: assert property (@(posedge clk) disable iff (!reset_n)
		state == fight_pkg::box_b_st |-> plot && color == `COLOR_B &&
		x - pos_b < BOX_WD && y - BOX_Y0 < BOX_HT)
		else begin fail_cnt++; $error("fighter B pixel outside its box"); end

	a_win_holds: assert property (@(posedge clk) disable iff (!reset_n) win |=> win)
		else begin fail_cnt++; $error("win dropped after it was raised"); end

endmodule

bind fight_top fight_chk #(.MAX_HEALTH(MAX_HEALTH)) u_chk (
	.clk      (clk),
	.reset_n  (reset_n),
	.state    (state),
	.x        (x),
	.y        (y),
	.color    (color),
	.plot     (plot),
	.pos_a    (pos_a),
	.pos_b    (pos_b),
	.health_a (health_a),
	.health_b (health_b),
	.win      (win)
);

`default_nettype wire

// ==== fight_config.svh ====
`ifndef FIGHT_CONFIG_SVH
`define FIGHT_CONFIG_SVH

// screen and pixel bus
`define SCREEN_W    160
`define SCREEN_H    120
`define X_W         8
`define Y_W         7
`define COLOR_W     3

// drawing geometry
`define BOX_W       24
`define BOX_H       40
`define FIGHTER_Y   40
`define BAR_H       4
`define BAR_A_X     5
`define BAR_B_X     80
`define BAR_Y       5

`define COLOR_BLACK 3'b000
`define COLOR_GREEN 3'b010
`define COLOR_RED   3'b100
`define COLOR_A     3'b011
`define COLOR_B     3'b101

// movement limits
`define START_A_X   10
`define START_B_X   120
`define STEP        4
`define A_MIN_X     4
`define B_MAX_X     140
`define GAP_MIN     23
`define HIT_DIST    22

// keyboard scan codes
`define KEY_START   8'h29
`define A_RIGHT     8'h23
`define A_LEFT      8'h1C
`define A_KICK      8'h1D
`define A_PUNCH     8'h1B
`define B_RIGHT     8'h4B
`define B_LEFT      8'h3B
`define B_KICK      8'h43
`define B_PUNCH     8'h42

`define DEF_HEALTH  70
`define DEF_HOLD    222000

`endif

// ==== fight_pkg.sv ====
`default_nettype none

package fight_pkg;

	// one move per player per frame
	typedef enum logic [2:0] {
		idle_mv,
		left_mv,
		right_mv,
		kick_mv,
		punch_mv
	} move_t;

	typedef enum logic [3:0] {
		reset_st,
		hold_st,   // power-up delay
		wait_st,   // waits for start key
		fill_st,
		pause_st,
		bar_a_st,
		bar_b_st,
		box_a_st,
		box_b_st,
		apply_st,
		game_st,
		win_st
	} state_t;

endpackage

`default_nettype wire

// ==== fight_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "fight_config.svh"

module fight_tb;

	localparam int MAX_HEALTH    = 3;
	localparam int HOLD_CYCLES   = 20;
	localparam int CLK_NS        = 4;
	localparam int FRAME_PIX     = `SCREEN_W * `SCREEN_H + 2 * MAX_HEALTH * `BAR_H +
		2 * `BOX_W * `BOX_H;
	localparam int QUIET_LIMIT   = 2 * HOLD_CYCLES + 4; // longer than the pause
	localparam int FRAME_CYCLES  = FRAME_PIX + HOLD_CYCLES + QUIET_LIMIT + 8;
	localparam int FRAME_TIMEOUT = 2 * FRAME_CYCLES;
	localparam int NUM_FRAMES    = 29;
	localparam int WATCHDOG_NS   = (NUM_FRAMES * FRAME_CYCLES + 1000) * CLK_NS * 2;
	localparam int START_DIST    = `START_B_X - `START_A_X;

	logic                clk;
	logic                reset_n;
	logic [7:0]          key_a;
	logic                key_a_valid;
	logic [7:0]          key_b;
	logic                key_b_valid;
	logic [`X_W-1:0]     x;
	logic [`Y_W-1:0]     y;
	logic [`COLOR_W-1:0] color;
	logic                plot;
	logic [6:0]          health_a;
	logic [6:0]          health_b;
	logic [7:0]          distance;
	logic                win;

	string test_name;
	int    plot_cnt = 0;
	int    test_errs = 0;
	int    error_total = 0;
	int    assert_mark = 0;
	int    tests_run = 0;
	int    tests_failed = 0;

	fight_top #(.MAX_HEALTH(MAX_HEALTH), .HOLD_CYCLES(HOLD_CYCLES)) UUT (
		.clk         (clk),
		.reset_n     (reset_n),
		.key_a       (key_a),
		.key_a_valid (key_a_valid),
		.key_b       (key_b),
		.key_b_valid (key_b_valid),
		.x           (x),
		.y           (y),
		.color       (color),
		.plot        (plot),
		.health_a    (health_a),
		.health_b    (health_b),
		.distance    (distance),
		.win         (win)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	always @(negedge clk) begin
		if (plot === 1'b1)
			plot_cnt++;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the game did not finish", WATCHDOG_NS);
		$display("Something failed");
		$finish;
	end

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
		assert_mark = UUT.u_chk.fail_cnt;
	endtask

	task automatic end_test();
		int asserts;
		asserts = UUT.u_chk.fail_cnt - assert_mark;
		if (asserts > 0)
			$display("test %s: %0d assertion failures during this test", test_name, asserts);
		if (test_errs == 0 && asserts == 0) begin
			$display("test %s: passed", test_name);
		end else begin
			$display("test %s: failed", test_name);
			tests_failed++;
		end
		tests_run++;
		error_total += test_errs;
	endtask

	task automatic check_value(input string what, input int expected, input int actual);
		if (expected != actual) begin
			$display("ERROR %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
			test_errs++;
		end
	endtask

	task automatic send_keys(input logic [7:0] code_a, input logic va,
			input logic [7:0] code_b, input logic vb);
		@(posedge clk);
		#1;
		key_a       = code_a;
		key_a_valid = va;
		key_b       = code_b;
		key_b_valid = vb;
		@(posedge clk);
		#1;
		key_a_valid = 1'b0;
		key_b_valid = 1'b0;
	endtask

	// one key press, then wait until the frame has been drawn and applied
	task automatic play_frame(input logic [7:0] code_a, input logic va,
			input logic [7:0] code_b, input logic vb);
		int mark;
		int quiet;
		int waited;
		mark = plot_cnt;
		send_keys(code_a, va, code_b, vb);
		quiet = 0;
		waited = 0;
		while (quiet < QUIET_LIMIT && waited < FRAME_TIMEOUT) begin
			@(negedge clk);
			waited++;
			if (plot === 1'b1)
				quiet = 0;
			else if (plot_cnt > mark)
				quiet++;
		end
		if (waited >= FRAME_TIMEOUT) begin
			$display("test %s: frame did not finish within %0d cycles", test_name, FRAME_TIMEOUT);
			test_errs++;
		end
		check_value("pixels per frame", FRAME_PIX, plot_cnt - mark);
	endtask

	task automatic check_fighters(input int exp_ha, input int exp_hb, input int exp_dist);
		check_value("health_a", exp_ha, int'(health_a));
		check_value("health_b", exp_hb, int'(health_b));
		check_value("distance", exp_dist, int'(distance));
	endtask

	initial begin
		int unsigned seed_draw;
		int          mark;
		logic [7:0]  strike_a;
		logic [7:0]  strike_b;
		seed_draw   = $urandom(89276);
		reset_n     = 1'b0;
		key_a       = 8'h00;
		key_a_valid = 1'b0;
		key_b       = 8'h00;
		key_b_valid = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset_n = 1'b1;

		start_test("reset");
		@(negedge clk);
		check_value("plot", 0, int'(plot));
		check_value("win", 0, int'(win));
		check_fighters(MAX_HEALTH, MAX_HEALTH, 0);
		send_keys(`A_RIGHT, 1'b1, 8'h00, 1'b0); // not the start key
		repeat (2 * QUIET_LIMIT) @(posedge clk);
		check_value("pixels before start", 0, plot_cnt);
		end_test();

		start_test("start_frame");
		play_frame(8'h00, 1'b0, `KEY_START, 1'b1);
		check_fighters(MAX_HEALTH, MAX_HEALTH, START_DIST);
		end_test();

		start_test("strike_out_of_range");
		strike_a = (seed_draw % 2 == 0) ? `A_KICK : `A_PUNCH;
		strike_b = ($urandom % 2 == 0) ? `B_KICK : `B_PUNCH;
		play_frame(strike_a, 1'b1, strike_b, 1'b1);
		check_fighters(MAX_HEALTH, MAX_HEALTH, START_DIST);
		end_test();

		start_test("approach");
		for (int k = 1; k <= 22; k++) begin
			play_frame(`A_RIGHT, 1'b1, 8'h00, 1'b0);
			check_value("distance", START_DIST - `STEP * k, int'(distance));
		end
		end_test();

		start_test("gap_limit");
		play_frame(`A_RIGHT, 1'b1, 8'h00, 1'b0);
		check_fighters(MAX_HEALTH, MAX_HEALTH, `HIT_DIST);
		end_test();

		start_test("punch_a");
		play_frame(`A_PUNCH, 1'b1, 8'h00, 1'b0);
		check_fighters(MAX_HEALTH, MAX_HEALTH - 1, `HIT_DIST);
		end_test();

		start_test("kick_b");
		play_frame(8'h00, 1'b0, `B_KICK, 1'b1);
		check_fighters(MAX_HEALTH - 1, MAX_HEALTH - 1, `HIT_DIST);
		end_test();

		start_test("win");
		play_frame(`A_PUNCH, 1'b1, 8'h00, 1'b0);
		check_value("win", 0, int'(win));
		play_frame(`A_PUNCH, 1'b1, 8'h00, 1'b0);
		check_fighters(MAX_HEALTH - 1, 0, `HIT_DIST);
		check_value("win", 1, int'(win));
		mark = plot_cnt;
		send_keys(`A_LEFT, 1'b1, `B_RIGHT, 1'b1); // game over, ignored
		repeat (2 * QUIET_LIMIT) @(posedge clk);
		check_value("pixels after win", 0, plot_cnt - mark);
		check_value("win", 1, int'(win));
		end_test();

		$display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
			tests_run, tests_failed, error_total, UUT.u_chk.fail_cnt);
		if (tests_failed == 0 && error_total == 0 && UUT.u_chk.fail_cnt == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== fight_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "fight_config.svh"

module fight_top #(
	parameter int MAX_HEALTH  = `DEF_HEALTH,
	parameter int HOLD_CYCLES = `DEF_HOLD
) (
	input  wire                 clk,
	input  wire                 reset_n,
	input  wire  [7:0]          key_a,
	input  wire                 key_a_valid,
	input  wire  [7:0]          key_b,
	input  wire                 key_b_valid,
	output logic [`X_W-1:0]     x,
	output logic [`Y_W-1:0]     y,
	output logic [`COLOR_W-1:0] color,
	output logic                plot,
	output logic [6:0]          health_a,
	output logic [6:0]          health_b,
	output logic [7:0]          distance,
	output logic                win
);

	fight_pkg::move_t  move_a;
	fight_pkg::move_t  move_b;
	fight_pkg::state_t state;
	logic              pending;
	logic              start_seen;
	logic              consume;
	logic              apply;
	logic              draw_done;
	logic [`X_W-1:0]   pos_a;
	logic [`X_W-1:0]   pos_b;

	key_decode u_keys (
		.clk         (clk),
		.reset_n     (reset_n),
		.key_a       (key_a),
		.key_a_valid (key_a_valid),
		.key_b       (key_b),
		.key_b_valid (key_b_valid),
		.consume     (consume),
		.move_a      (move_a),
		.move_b      (move_b),
		.pending     (pending),
		.start_seen  (start_seen)
	);

	fighter_execute #(.MAX_HEALTH(MAX_HEALTH)) u_fighters (
		.clk      (clk),
		.reset_n  (reset_n),
		.apply    (apply),
		.move_a   (move_a),
		.move_b   (move_b),
		.pos_a    (pos_a),
		.pos_b    (pos_b),
		.health_a (health_a),
		.health_b (health_b),
		.distance (distance),
		.win_flag (win)
	);

	frame_sequencer #(.HOLD_CYCLES(HOLD_CYCLES)) u_seq (
		.clk        (clk),
		.reset_n    (reset_n),
		.start_seen (start_seen),
		.pending    (pending),
		.draw_done  (draw_done),
		.win_flag   (win),
		.state      (state),
		.apply      (apply),
		.consume    (consume)
	);

	pixel_result #(.MAX_HEALTH(MAX_HEALTH)) u_pixels (
		.clk       (clk),
		.reset_n   (reset_n),
		.state     (state),
		.pos_a     (pos_a),
		.pos_b     (pos_b),
		.health_a  (health_a),
		.health_b  (health_b),
		.x         (x),
		.y         (y),
		.color     (color),
		.plot      (plot),
		.draw_done (draw_done)
	);

endmodule

`default_nettype wire

// ==== fighter_execute.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "fight_config.svh"

module fighter_execute #(
	parameter int MAX_HEALTH = `DEF_HEALTH
) (
	input  wire                    clk,
	input  wire                    reset_n,
	input  wire                    apply,
	input  wire  fight_pkg::move_t move_a,
	input  wire  fight_pkg::move_t move_b,
	output logic [`X_W-1:0]        pos_a,
	output logic [`X_W-1:0]        pos_b,
	output logic [6:0]             health_a,
	output logic [6:0]             health_b,
	output logic [7:0]             distance,
	output logic                   win_flag
);

	localparam logic [`X_W-1:0] STEP    = `STEP;
	localparam logic [`X_W-1:0] GAP     = `GAP_MIN;
	localparam logic [`X_W-1:0] A_MIN   = `A_MIN_X;
	localparam logic [`X_W-1:0] B_MAX   = `B_MAX_X;
	localparam logic [7:0]      HIT     = `HIT_DIST;
	localparam logic [6:0]      FULL_HP = 7'(MAX_HEALTH);

	logic [`X_W-1:0] pos_a_nxt;
	logic [`X_W-1:0] pos_b_nxt;
	logic            strike_a;
	logic            strike_b;

	// both fighters judged against the old positions
	always_comb begin
		pos_a_nxt = pos_a;
		pos_b_nxt = pos_b;
		if (move_a == fight_pkg::right_mv && pos_a < pos_b - GAP)
			pos_a_nxt = pos_a + STEP;
		else if (move_a == fight_pkg::left_mv && pos_a > A_MIN)
			pos_a_nxt = pos_a - STEP;
		if (move_b == fight_pkg::right_mv && pos_b < B_MAX)
			pos_b_nxt = pos_b + STEP;
		else if (move_b == fight_pkg::left_mv && pos_b > pos_a + GAP)
			pos_b_nxt = pos_b - STEP;
	end

	// distance here is still the one from the previous frame
	assign strike_a = (move_a == fight_pkg::kick_mv || move_a == fight_pkg::punch_mv) &&
		(distance == HIT);
	assign strike_b = (move_b == fight_pkg::kick_mv || move_b == fight_pkg::punch_mv) &&
		(distance == HIT);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pos_a    <= `START_A_X;
			pos_b    <= `START_B_X;
			health_a <= FULL_HP;
			health_b <= FULL_HP;
			distance <= '0;
		end else if (apply) begin
			pos_a    <= pos_a_nxt;
			pos_b    <= pos_b_nxt;
			distance <= 8'(pos_b_nxt - pos_a_nxt);
			if (strike_a && health_b != '0)
				health_b <= health_b - 1'b1;
			if (strike_b && health_a != '0)
				health_a <= health_a - 1'b1;
		end
	end

	assign win_flag = (health_a == '0) || (health_b == '0);

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
fight_pkg.sv
key_decode.sv
fighter_execute.sv
frame_sequencer.sv
pixel_result.sv
fight_top.sv
fight_chk.sv
fight_tb.sv

// ==== frame_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "fight_config.svh"

module frame_sequencer #(
	parameter int HOLD_CYCLES = `DEF_HOLD
) (
	input  wire               clk,
	input  wire               reset_n,
	input  wire               start_seen,
	input  wire               pending,
	input  wire               draw_done,
	input  wire               win_flag,
	output fight_pkg::state_t state,
	output logic              apply,
	output logic              consume
);

	localparam int              HC_W      = $clog2(HOLD_CYCLES + 1);
	localparam logic [HC_W-1:0] HOLD_LAST = HC_W'(HOLD_CYCLES - 1);

	fight_pkg::state_t state_nxt;
	logic [HC_W-1:0]   hold_cnt;
	logic              hold_over;

	assign hold_over = (hold_cnt == HOLD_LAST);

	always_comb begin
		state_nxt = state;
		case (state)
			fight_pkg::reset_st:
				state_nxt = fight_pkg::hold_st;
			fight_pkg::hold_st:
				if (hold_over)
					state_nxt = fight_pkg::wait_st;
			fight_pkg::wait_st:
				if (start_seen)
					state_nxt = fight_pkg::fill_st;
			fight_pkg::fill_st:
				if (draw_done)
					state_nxt = fight_pkg::pause_st;
			fight_pkg::pause_st:
				if (hold_over)
					state_nxt = fight_pkg::bar_a_st;
			fight_pkg::bar_a_st:
				if (draw_done)
					state_nxt = fight_pkg::bar_b_st;
			fight_pkg::bar_b_st:
				if (draw_done)
					state_nxt = fight_pkg::box_a_st;
			fight_pkg::box_a_st:
				if (draw_done)
					state_nxt = fight_pkg::box_b_st;
			fight_pkg::box_b_st:
				if (draw_done)
					state_nxt = fight_pkg::apply_st;
			fight_pkg::apply_st:
				state_nxt = fight_pkg::game_st;
			fight_pkg::game_st: begin
				if (win_flag)
					state_nxt = fight_pkg::win_st;
				else if (pending)
					state_nxt = fight_pkg::fill_st;
			end
			fight_pkg::win_st:
				state_nxt = fight_pkg::win_st; // game over
			default:
				state_nxt = fight_pkg::reset_st;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n)
			state <= fight_pkg::reset_st;
		else
			state <= state_nxt;
	end

	// shared by hold and pause
	always_ff @(posedge clk) begin
		if (!reset_n)
			hold_cnt <= '0;
		else if (state_nxt != state)
			hold_cnt <= '0;
		else if (state == fight_pkg::hold_st || state == fight_pkg::pause_st)
			hold_cnt <= hold_cnt + 1'b1;
	end

	assign apply = (state == fight_pkg::apply_st);

	// start key dropped on the way out of wait
	assign consume = apply || (state == fight_pkg::wait_st && start_seen);

endmodule

`default_nettype wire

// ==== key_decode.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "fight_config.svh"

module key_decode (
	input  wire              clk,
	input  wire              reset_n,
	input  wire        [7:0] key_a,
	input  wire              key_a_valid,
	input  wire        [7:0] key_b,
	input  wire              key_b_valid,
	input  wire              consume,
	output fight_pkg::move_t move_a,
	output fight_pkg::move_t move_b,
	output logic             pending,
	output logic             start_seen
);

	logic [7:0] code_a;
	logic [7:0] code_b;

	function automatic fight_pkg::move_t decode(
		input logic [7:0] code,
		input logic [7:0] right_code,
		input logic [7:0] left_code,
		input logic [7:0] kick_code,
		input logic [7:0] punch_code
	);
		case (code)
			right_code: decode = fight_pkg::right_mv;
			left_code:  decode = fight_pkg::left_mv;
			kick_code:  decode = fight_pkg::kick_mv;
			punch_code: decode = fight_pkg::punch_mv;
			default:    decode = fight_pkg::idle_mv;
		endcase
	endfunction

	// new key wins over consume
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			code_a <= '0;
			code_b <= '0;
		end else begin
			if (key_a_valid)
				code_a <= key_a;
			else if (consume)
				code_a <= '0;
			if (key_b_valid)
				code_b <= key_b;
			else if (consume)
				code_b <= '0;
		end
	end

	assign move_a = decode(code_a, `A_RIGHT, `A_LEFT, `A_KICK, `A_PUNCH);
	assign move_b = decode(code_b, `B_RIGHT, `B_LEFT, `B_KICK, `B_PUNCH);

	assign pending    = (code_a != '0) || (code_b != '0);
	assign start_seen = (code_a == `KEY_START) || (code_b == `KEY_START);

endmodule

`default_nettype wire

// ==== pixel_result.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "fight_config.svh"

module pixel_result #(
	parameter int MAX_HEALTH = `DEF_HEALTH
) (
	input  wire                     clk,
	input  wire                     reset_n,
	input  wire  fight_pkg::state_t state,
	input  wire  [`X_W-1:0]         pos_a,
	input  wire  [`X_W-1:0]         pos_b,
	input  wire  [6:0]              health_a,
	input  wire  [6:0]              health_b,
	output logic [`X_W-1:0]         x,
	output logic [`Y_W-1:0]         y,
	output logic [`COLOR_W-1:0]     color,
	output logic                    plot,
	output logic                    draw_done
);

	localparam logic [`X_W-1:0] BAR_LAST = `X_W'(MAX_HEALTH - 1);
	localparam logic [`X_W-1:0] BAR_A_X  = `BAR_A_X;
	localparam logic [`X_W-1:0] BAR_B_X  = `BAR_B_X;
	localparam logic [`Y_W-1:0] BAR_Y    = `BAR_Y;
	localparam logic [`Y_W-1:0] BOX_Y    = `FIGHTER_Y;

	logic [`X_W-1:0] scan_in;   // fast counter
	logic [`X_W-1:0] scan_out;
	logic [`X_W-1:0] in_max;
	logic [`X_W-1:0] out_max;
	logic            drawing;
	logic [`X_W-1:0] bar_x0;
	logic [`X_W-1:0] bar_hp;
	logic [`X_W-1:0] box_x0;

	// scan size per draw
	always_comb begin
		drawing = 1'b1;
		in_max  = '0;
		out_max = '0;
		case (state)
			fight_pkg::fill_st: begin
				in_max  = `X_W'(`SCREEN_W - 1);
				out_max = `X_W'(`SCREEN_H - 1);
			end
			fight_pkg::bar_a_st, fight_pkg::bar_b_st: begin
				in_max  = `X_W'(`BAR_H - 1); // rows inside a column
				out_max = BAR_LAST;
			end
			fight_pkg::box_a_st, fight_pkg::box_b_st: begin
				in_max  = `X_W'(`BOX_W - 1);
				out_max = `X_W'(`BOX_H - 1);
			end
			default:
				drawing = 1'b0;
		endcase
	end

	assign draw_done = drawing && (scan_in == in_max) && (scan_out == out_max);

	// back to zero after the last pixel of each draw
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			scan_in  <= '0;
			scan_out <= '0;
		end else if (!drawing || draw_done) begin
			scan_in  <= '0;
			scan_out <= '0;
		end else if (scan_in == in_max) begin
			scan_in  <= '0;
			scan_out <= scan_out + 1'b1;
		end else begin
			scan_in <= scan_in + 1'b1;
		end
	end

	assign bar_x0 = (state == fight_pkg::bar_a_st) ? BAR_A_X : BAR_B_X;
	assign bar_hp = (state == fight_pkg::bar_a_st) ? `X_W'(health_a) : `X_W'(health_b);
	assign box_x0 = (state == fight_pkg::box_a_st) ? pos_a : pos_b;

	always_comb begin
		x     = '0;
		y     = '0;
		color = `COLOR_BLACK;
		case (state)
			fight_pkg::fill_st: begin
				x = scan_in;
				y = scan_out[`Y_W-1:0];
			end
			fight_pkg::bar_a_st, fight_pkg::bar_b_st: begin
				x     = bar_x0 + scan_out;
				y     = BAR_Y + scan_in[`Y_W-1:0];
				color = (scan_out <= bar_hp) ? `COLOR_GREEN : `COLOR_RED;
			end
			fight_pkg::box_a_st, fight_pkg::box_b_st: begin
				x     = box_x0 + scan_in;
				y     = BOX_Y + scan_out[`Y_W-1:0];
				color = (state == fight_pkg::box_a_st) ? `COLOR_A : `COLOR_B;
			end
			default: ;
		endcase
	end

	assign plot = drawing;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the fight testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module fight_tb -f flist.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# keep running past the first assertion error so the testbench can report
out=$(./obj_dir/Vfight_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1
